/* flist.f */
+incdir+common
+incdir+test
common/mv_data_pkg.sv
common/mv_ctrl_pkg.sv
hw/core/mv_core.sv
hw/core/mv_core_array.sv
hw/mv_loader.sv
hw/mv_sequencer.sv
hw/mv_top.sv
test/tb_mv_top.sv

/* Makefile */
BUILD := obj_dir
LOG   := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module tb_mv_top

sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_mv_top \
		-Mdir $(BUILD) -o sim_mv
	./$(BUILD)/sim_mv | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* test/tb_mv_tasks.svh */
`ifndef TB_MV_TASKS_SVH
`define TB_MV_TASKS_SVH

// xorshift32
function logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// row times vector modulo 2^32
function automatic mv_data_pkg::word_t model_dot(input int row);
    mv_data_pkg::word_t sum;
    sum = '0;
    for (int c = 0; c < `MV_COLS; c++) begin
        sum = sum + mat[row][c] * vec[c];
    end
    return sum;
endfunction

task automatic compare_word(input string name, input mv_data_pkg::word_t got,
                            input mv_data_pkg::word_t expected);
    check_cnt++;
    if (got !== expected) begin
        err_cnt++;
        $display("Fail at %0t: %s got %h, expected %h", $time, name, got, expected);
    end
endtask

task automatic compare_flag(input string name, input logic got, input logic expected);
    check_cnt++;
    if (got !== expected) begin
        err_cnt++;
        $display("Fail at %0t: %s got %b, expected %b", $time, name, got, expected);
    end
endtask

task automatic report_test(input int num, input string name, input int errs_before);
    if (err_cnt == errs_before) begin
        $display("test %0d %s: ok", num, name);
    end else begin
        $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
    end
endtask

// even column first, then its odd partner
task automatic load_matrix();
    for (int r = 0; r < `MV_CORES; r++) begin
        for (int c = 0; c < `MV_COLS; c++) begin
            @(posedge clk);
            load_v    <= 1'b1;
            load_row  <= mv_data_pkg::row_t'(r);
            load_col  <= mv_data_pkg::col_t'(c);
            load_word <= mat[r][c];
        end
    end
    @(posedge clk);
    load_v <= 1'b0;
    repeat (2) @(posedge clk); // last pair write reaches the banks
endtask

task automatic run_vector(input bit with_gaps);
    int gap;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    compare_flag("busy", busy, 1'b1);
    for (int k = 0; k < `MV_COLS; k++) begin
        gap = with_gaps ? int'(xorshift() % 3) : 0;
        repeat (gap) begin
            @(posedge clk);
            vec_v    <= 1'b0;
            vec_data <= xorshift(); // junk the sequencer ignores
        end
        @(posedge clk);
        vec_v    <= 1'b1;
        vec_data <= vec[k];
    end
    @(posedge clk);
    vec_v <= 1'b0; // this edge takes the last word
    for (int lat = 0; lat < `MV_EXEC_LAT; lat++) begin
        @(negedge clk);
        compare_flag("result_v", result_v, 1'b0);
    end
    @(negedge clk);
    if (!result_v) begin
        err_cnt++;
        $display("result_v did not rise %0d cycles after the last vector word", `MV_EXEC_LAT);
        return;
    end
    for (int i = 0; i < `MV_CORES; i++) begin
        if (i > 0) begin
            @(negedge clk);
        end
        compare_flag("result_v", result_v, 1'b1);
        compare_flag("done", done, i == `MV_CORES - 1);
        compare_flag("busy", busy, 1'b1);
        res[i] = result;
    end
    @(negedge clk);
    compare_flag("result_v", result_v, 1'b0);
    compare_flag("done", done, 1'b0);
    compare_flag("busy", busy, 1'b0);
endtask

task automatic identity_rows();
    int errs;
    errs = err_cnt;
    for (int r = 0; r < `MV_CORES; r++) begin
        for (int c = 0; c < `MV_COLS; c++) begin
            mat[r][c] = (c == r) ? 32'd1 : 32'd0;
        end
    end
    for (int c = 0; c < `MV_COLS; c++) begin
        vec[c] = xorshift();
    end
    load_matrix();
    run_vector(1'b0);
    for (int r = 0; r < `MV_CORES; r++) begin
        compare_word($sformatf("result row %0d", r), res[r], vec[r]);
    end
    report_test(1, "identity rows", errs);
endtask

task automatic random_products();
    int errs;
    errs = err_cnt;
    for (int r = 0; r < `MV_CORES; r++) begin
        for (int c = 0; c < `MV_COLS; c++) begin
            mat[r][c] = xorshift();
        end
    end
    for (int c = 0; c < `MV_COLS; c++) begin
        vec[c] = xorshift();
    end
    load_matrix();
    run_vector(1'b0); // also checks the 3 cycle latency
    for (int r = 0; r < `MV_CORES; r++) begin
        compare_word($sformatf("result row %0d", r), res[r], model_dot(r));
    end
    report_test(2, "random products", errs);
endtask

task automatic gapped_stream();
    int errs;
    errs = err_cnt;
    for (int c = 0; c < `MV_COLS; c++) begin
        vec[c] = xorshift();
    end
    run_vector(1'b0);
    for (int r = 0; r < `MV_CORES; r++) begin
        compare_word($sformatf("result row %0d", r), res[r], model_dot(r));
    end
    run_vector(1'b1);
    for (int r = 0; r < `MV_CORES; r++) begin
        compare_word($sformatf("gapped result row %0d", r), res[r], model_dot(r));
    end
    report_test(3, "gapped stream", errs);
endtask

task automatic back_to_back_runs();
    int errs;
    errs = err_cnt;
    for (int c = 0; c < `MV_COLS; c++) begin
        vec[c] = xorshift();
    end
    run_vector(1'b0);
    for (int c = 0; c < `MV_COLS; c++) begin
        vec[c] = xorshift();
    end
    run_vector(1'b0);
    // any leftover from the first run shows up here
    for (int r = 0; r < `MV_CORES; r++) begin
        compare_word($sformatf("second run row %0d", r), res[r], model_dot(r));
    end
    report_test(4, "back to back runs", errs);
endtask

task automatic reset_and_flags();
    int errs;
    errs = err_cnt;
    // reset lands while results are streaming out
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    for (int k = 0; k < `MV_COLS; k++) begin
        @(posedge clk);
        vec_v    <= 1'b1;
        vec_data <= vec[k];
    end
    @(posedge clk);
    vec_v <= 1'b0;
    repeat (`MV_EXEC_LAT + 2) @(negedge clk);
    compare_flag("result_v", result_v, 1'b1);
    compare_flag("busy", busy, 1'b1);
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_flag("result_v", result_v, 1'b0);
    compare_flag("busy", busy, 1'b0);
    compare_flag("done", done, 1'b0);
    run_vector(1'b0); // banks keep the matrix over reset
    for (int r = 0; r < `MV_CORES; r++) begin
        compare_word($sformatf("result row %0d", r), res[r], model_dot(r));
    end
    report_test(5, "reset and flags", errs);
endtask

`endif

/* test/tb_mv_top.sv */
`include "mv_consts.svh"

module tb_mv_top;

    localparam int LOAD_CYCLES = `MV_CORES * `MV_COLS + 4;
    localparam int RUN_CYCLES  = 3 * `MV_COLS + `MV_CORES + 16; // gaps up to two cycles
    localparam int MAX_CYCLES  = 3 * LOAD_CYCLES + 8 * RUN_CYCLES + 64;

    logic               clk;
    logic               rst_n;
    logic               load_v;
    mv_data_pkg::row_t  load_row;
    mv_data_pkg::col_t  load_col;
    mv_data_pkg::word_t load_word;
    logic               start;
    logic               vec_v;
    mv_data_pkg::word_t vec_data;
    mv_data_pkg::word_t result;
    logic               result_v;
    logic               busy;
    logic               done;

    mv_data_pkg::word_t mat [0:`MV_CORES-1][0:`MV_COLS-1];
    mv_data_pkg::word_t vec [0:`MV_COLS-1];
    mv_data_pkg::word_t res [0:`MV_CORES-1];

    logic [31:0] rng_state;
    int          cycle_cnt;
    int          check_cnt;
    int          err_cnt;

    mv_top mv_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_v    (load_v),
        .load_row  (load_row),
        .load_col  (load_col),
        .load_word (load_word),
        .start     (start),
        .vec_v     (vec_v),
        .vec_data  (vec_data),
        .result    (result),
        .result_v  (result_v),
        .busy      (busy),
        .done      (done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    `include "tb_mv_tasks.svh"

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        load_v    = 1'b0;
        load_row  = '0;
        load_col  = '0;
        load_word = '0;
        start     = 1'b0;
        vec_v     = 1'b0;
        vec_data  = '0;
        rng_state = 32'h8bef7a4e;
        cycle_cnt = 0;
        check_cnt = 0;
        err_cnt   = 0;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        identity_rows();
        random_products();
        gapped_stream();
        back_to_back_runs();
        reset_and_flags();

        $display("tests: 5, checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* hw/mv_top.sv */
module mv_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_v,
    input  mv_data_pkg::row_t  load_row,
    input  mv_data_pkg::col_t  load_col,
    input  mv_data_pkg::word_t load_word,
    input  logic               start,
    input  logic               vec_v,
    input  mv_data_pkg::word_t vec_data,
    output mv_data_pkg::word_t result,
    output logic               result_v,
    output logic               busy,
    output logic               done
);

    logic                    mat_v;
    mv_data_pkg::row_t       mat_row;
    mv_data_pkg::pair_addr_t mat_a;
    mv_data_pkg::pair_t      mat_d;

    logic                    init;
    logic                    exec;
    mv_data_pkg::col_t       exec_mat_addr;
    mv_data_pkg::word_t      exec_src_data;
    logic                    update;
    logic                    out_period;

    assign result_v = out_period; // results stream out during out_period

    mv_loader loader_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_v    (load_v),
        .load_row  (load_row),
        .load_col  (load_col),
        .load_word (load_word),
        .mat_v     (mat_v),
        .mat_row   (mat_row),
        .mat_a     (mat_a),
        .mat_d     (mat_d)
    );

    mv_sequencer sequencer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .vec_v         (vec_v),
        .vec_data      (vec_data),
        .init          (init),
        .exec          (exec),
        .exec_mat_addr (exec_mat_addr),
        .exec_src_data (exec_src_data),
        .update        (update),
        .out_period    (out_period),
        .busy          (busy),
        .done          (done)
    );

    mv_core_array core_array_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .mat_v         (mat_v),
        .mat_row       (mat_row),
        .mat_a         (mat_a),
        .mat_d         (mat_d),
        .init          (init),
        .exec          (exec),
        .exec_mat_addr (exec_mat_addr),
        .exec_src_data (exec_src_data),
        .update        (update),
        .out_period    (out_period),
        .result        (result)
    );

endmodule

/* hw/mv_sequencer.sv */
`include "mv_consts.svh"

module mv_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               vec_v,
    input  mv_data_pkg::word_t vec_data,
    output logic               init,
    output logic               exec,
    output mv_data_pkg::col_t  exec_mat_addr,
    output mv_data_pkg::word_t exec_src_data,
    output logic               update,
    output logic               out_period,
    output logic               busy,
    output logic               done
);

    localparam int DRAIN_W = $clog2(`MV_EXEC_LAT);

    mv_ctrl_pkg::seq_state_t state;
    mv_ctrl_pkg::out_cnt_t   out_cnt;
    mv_data_pkg::col_t       col_cnt;
    logic [DRAIN_W-1:0]      drain_cnt;
    mv_data_pkg::word_t      src_d1;
    logic                    last_col;

    assign last_col = (col_cnt == mv_data_pkg::col_t'(`MV_COLS - 1));

    assign init       = (state == mv_ctrl_pkg::CLEAR);
    assign out_period = (state == mv_ctrl_pkg::OUTPUT);
    assign update     = out_period && (out_cnt == '0);
    assign done       = out_period && (out_cnt == mv_ctrl_pkg::out_cnt_t'(`MV_CORES - 1));
    assign busy       = (state != mv_ctrl_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= mv_ctrl_pkg::IDLE;
            col_cnt   <= '0;
            drain_cnt <= '0;
            out_cnt   <= '0;
        end else begin
            case (state)
                mv_ctrl_pkg::IDLE: begin
                    if (start) begin
                        state <= mv_ctrl_pkg::CLEAR;
                    end
                end
                mv_ctrl_pkg::CLEAR: begin
                    col_cnt <= '0;
                    state   <= mv_ctrl_pkg::RUN;
                end
                mv_ctrl_pkg::RUN: begin
                    if (vec_v) begin
                        col_cnt <= col_cnt + 1'b1;
                        if (last_col) begin
                            drain_cnt <= '0;
                            state     <= mv_ctrl_pkg::DRAIN;
                        end
                    end
                end
                mv_ctrl_pkg::DRAIN: begin
                    // update lands MV_EXEC_LAT edges after the last word
                    if (drain_cnt == DRAIN_W'(`MV_EXEC_LAT - 1)) begin
                        out_cnt <= '0;
                        state   <= mv_ctrl_pkg::OUTPUT;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                mv_ctrl_pkg::OUTPUT: begin
                    out_cnt <= out_cnt + 1'b1;
                    if (done) begin
                        state <= mv_ctrl_pkg::IDLE;
                    end
                end
                default: state <= mv_ctrl_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec <= 1'b0;
        end else begin
            exec <= vec_v && (state == mv_ctrl_pkg::RUN);
        end
    end

    // src data trails exec by one cycle to meet exec_next in the core
    always_ff @(posedge clk) begin
        exec_mat_addr <= col_cnt;
        src_d1        <= vec_data;
        exec_src_data <= src_d1;
    end

    a_vec_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        vec_v |-> (state == mv_ctrl_pkg::RUN));

endmodule

/* hw/mv_loader.sv */
module mv_loader (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_v,
    input  mv_data_pkg::row_t       load_row,
    input  mv_data_pkg::col_t       load_col,
    input  mv_data_pkg::word_t      load_word,
    output logic                    mat_v,
    output mv_data_pkg::row_t       mat_row,
    output mv_data_pkg::pair_addr_t mat_a,
    output mv_data_pkg::pair_t      mat_d
);

    logic                    held_v;
    mv_data_pkg::word_t      held_word;
    mv_data_pkg::row_t       held_row;
    mv_data_pkg::pair_addr_t held_a;

    mv_data_pkg::pair_addr_t load_a;
    logic                    load_odd;

    assign load_a   = load_col[$bits(load_col)-1:1];
    assign load_odd = load_col[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_v <= 1'b0;
            mat_v  <= 1'b0;
        end else begin
            mat_v <= load_v && load_odd;
            if (load_v) begin
                held_v <= !load_odd; // odd word consumes the held one
            end
        end
    end

    // even word waits here
    always_ff @(posedge clk) begin
        if (load_v && !load_odd) begin
            held_word <= load_word;
            held_row  <= load_row;
            held_a    <= load_a;
        end
    end

    always_ff @(posedge clk) begin
        if (load_v && load_odd) begin
            mat_row <= load_row;
            mat_a   <= load_a;
            mat_d   <= {load_word, held_word};
        end
    end

    // odd word must complete the pair that is being held
    a_pair_match: assert property (@(posedge clk) disable iff (!rst_n)
        (load_v && load_odd) |-> (held_v && load_row == held_row && load_a == held_a));

endmodule

/* hw/core/mv_core_array.sv */
`include "mv_consts.svh"

module mv_core_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mat_v,
    input  mv_data_pkg::row_t       mat_row,
    input  mv_data_pkg::pair_addr_t mat_a,
    input  mv_data_pkg::pair_t      mat_d,
    input  logic                    init,
    input  logic                    exec,
    input  mv_data_pkg::col_t       exec_mat_addr,
    input  mv_data_pkg::word_t      exec_src_data,
    input  logic                    update,
    input  logic                    out_period,
    output mv_data_pkg::word_t      result
);

    logic [`MV_CORES-1:0] core_we;
    mv_data_pkg::word_t   acc_chain [0:`MV_CORES];

    // one-hot write enable from the row index
    assign core_we = mat_v ? (`MV_CORES'(1) << mat_row) : '0;

    assign acc_chain[`MV_CORES] = '0; // tail of the chain
    assign result = acc_chain[0];

    for (genvar i = 0; i < `MV_CORES; i++) begin : g_core
        mv_core core_inst (
            .clk           (clk),
            .rst_n         (rst_n),
            .init          (init),
            .mat_v         (core_we[i]),
            .mat_a         (mat_a),
            .mat_d         (mat_d),
            .exec          (exec),
            .out_period    (out_period),
            .update        (update),
            .exec_mat_addr (exec_mat_addr),
            .exec_src_data (exec_src_data),
            .acc_next      (acc_chain[i+1]),
            .acc           (acc_chain[i])
        );
    end

endmodule

/* hw/core/mv_core.sv */
`include "mv_consts.svh"

module mv_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    init,
    input  logic                    mat_v,
    input  mv_data_pkg::pair_addr_t mat_a,
    input  mv_data_pkg::pair_t      mat_d,
    input  logic                    exec,
    input  logic                    out_period,
    input  logic                    update,
    input  mv_data_pkg::col_t       exec_mat_addr,
    input  mv_data_pkg::word_t      exec_src_data,
    input  mv_data_pkg::word_t      acc_next,
    output mv_data_pkg::word_t      acc
);

    mv_data_pkg::word_t bank_even [0:`MV_COLS/2-1];
    mv_data_pkg::word_t bank_odd  [0:`MV_COLS/2-1];

    mv_data_pkg::word_t exec_mat_data;
    mv_data_pkg::word_t m2;
    mv_data_pkg::word_t d2;
    mv_data_pkg::word_t acc_left;
    mv_data_pkg::word_t acc_right;

    logic init_next;
    logic init_next_next;
    logic exec_next;
    logic exec_next_next;

    // all cores present acc_left on update, then the chain shifts
    assign acc = update ? acc_left : acc_right;

    always_ff @(posedge clk) begin
        if (mat_v) begin
            bank_even[mat_a] <= mat_d[`MV_WORD_W-1:0];
            bank_odd[mat_a]  <= mat_d[2*`MV_WORD_W-1:`MV_WORD_W];
        end
    end

    // low column bit picks the bank
    always_ff @(posedge clk) begin
        if (exec_mat_addr[0]) begin
            exec_mat_data <= bank_odd[exec_mat_addr[$bits(exec_mat_addr)-1:1]];
        end else begin
            exec_mat_data <= bank_even[exec_mat_addr[$bits(exec_mat_addr)-1:1]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_next      <= 1'b0;
            init_next_next <= 1'b0;
            exec_next      <= 1'b0;
            exec_next_next <= 1'b0;
        end else begin
            init_next      <= init;
            init_next_next <= init_next;
            exec_next      <= exec;
            exec_next_next <= exec_next;
        end
    end

    // operand registers ahead of the multiplier
    always_ff @(posedge clk) begin
        if (exec_next) begin
            m2 <= exec_mat_data;
            d2 <= exec_src_data;
        end
    end

    always_ff @(posedge clk) begin
        if (init_next_next) begin
            acc_left <= '0;
        end else if (exec_next_next) begin
            acc_left <= acc_left + m2 * d2; // keeps the low 32 bits
        end
        if (out_period) begin
            acc_right <= acc_next;
        end
    end

    // sequencer never overlaps clear and accumulate
    a_init_exec_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(init && exec));

endmodule

/* common/mv_ctrl_pkg.sv */
`include "mv_consts.svh"

package mv_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,  // init pulse
        RUN,
        DRAIN,  // wait out the core pipeline
        OUTPUT
    } seq_state_t;

    // counts results leaving the chain
    typedef logic [$clog2(`MV_CORES)-1:0] out_cnt_t;

endpackage

/* common/mv_data_pkg.sv */
`include "mv_consts.svh"

package mv_data_pkg;

    // matrix element, vector element and accumulator
    typedef logic [`MV_WORD_W-1:0] word_t;

    typedef logic [2*`MV_WORD_W-1:0] pair_t; // {odd, even}

    // column index into one row
    typedef logic [$clog2(`MV_COLS)-1:0] col_t;

    typedef logic [$clog2(`MV_COLS)-2:0] pair_addr_t; // col / 2

    // selects one core
    typedef logic [$clog2(`MV_CORES)-1:0] row_t;

endpackage

/* common/mv_consts.svh */
`ifndef MV_CONSTS_SVH
`define MV_CONSTS_SVH

// array geometry
`define MV_CORES    8
`define MV_COLS     128

`define MV_WORD_W   32

// exec strobe to acc_left holding the product
`define MV_EXEC_LAT 3

`endif
